// File: verilog/poke_pkg.sv
package poke_pkg;

  // ----------------------------------------
  // Widths with a meaning
  // ----------------------------------------
  typedef logic [7:0] keycode_t;  // Keyboard usage code
  typedef logic [7:0] hp_t;
  typedef logic [1:0] mon_idx_t;  // Team slot, 0 to 2
  typedef logic [1:0] move_t;

  // Move commands keep their move number in the low two bits
  typedef enum logic [2:0] {
    CMD_MOVE0   = 3'd0,
    CMD_MOVE1   = 3'd1,
    CMD_MOVE2   = 3'd2,
    CMD_MOVE3   = 3'd3,
    CMD_SWITCH  = 3'd4,
    CMD_RESTART = 3'd5
  } cmd_t;

  typedef enum logic [1:0] {
    HP_GREEN  = 2'd0,
    HP_YELLOW = 2'd1,
    HP_RED    = 2'd2
  } hp_class_t;

  // ----------------------------------------
  // Keyboard usage codes
  // ----------------------------------------
  localparam keycode_t KEY_A     = 8'h04;
  localparam keycode_t KEY_S     = 8'h16;
  localparam keycode_t KEY_D     = 8'h07;
  localparam keycode_t KEY_F     = 8'h09;
  localparam keycode_t KEY_SPACE = 8'h2C;  // Switch monster
  localparam keycode_t KEY_ENTER = 8'h28;  // Restart battle

  // ----------------------------------------
  // Stat tables
  // ----------------------------------------
  localparam int TEAM_SIZE = 3;

  // Damage per move number
  localparam hp_t [0:3] MOVE_POWER = {8'd10, 8'd16, 8'd22, 8'd30};

  localparam hp_t [0:TEAM_SIZE-1] MY_MAX_HP    = {8'd60, 8'd50, 8'd70};
  localparam hp_t [0:TEAM_SIZE-1] ENEMY_MAX_HP = {8'd40, 8'd55, 8'd65};

  // Counterattack strength of each enemy slot
  localparam hp_t [0:TEAM_SIZE-1] ENEMY_POWER  = {8'd8, 8'd11, 8'd14};

endpackage

// File: verilog/key_decode.sv
module key_decode #(
  parameter int CMD_CREDITS = 4
) (
  input  logic               Clk,
  input  logic               arst_n,
  input  poke_pkg::keycode_t keycode,
  input  logic               cmd_credit,
  output logic               cmd_valid,
  output poke_pkg::cmd_t     cmd,
  output logic               key_drop
);
  import poke_pkg::*;

  localparam int CW = $clog2(CMD_CREDITS + 1);

  keycode_t      key_q;     // Sampled keycode
  keycode_t      key_prev;  // Keycode one cycle earlier
  logic          mapped;
  cmd_t          key_cmd;
  logic          press;
  logic          have_credit;
  logic          spend;
  logic [CW-1:0] credits;

  // ----------------------------------------
  // Keycode to command
  // ----------------------------------------
  always_comb begin
    mapped  = 1'b1;
    key_cmd = CMD_MOVE0;
    case (key_q)
      KEY_A:     key_cmd = CMD_MOVE0;
      KEY_S:     key_cmd = CMD_MOVE1;
      KEY_D:     key_cmd = CMD_MOVE2;
      KEY_F:     key_cmd = CMD_MOVE3;
      KEY_SPACE: key_cmd = CMD_SWITCH;
      KEY_ENTER: key_cmd = CMD_RESTART;
      default:   mapped  = 1'b0;  // Unused keys and key release
    endcase
  end

  // New press only on a change to a mapped code
  assign press       = mapped && (key_q != key_prev);
  assign have_credit = (credits != '0);
  assign spend       = press && have_credit;

  // ----------------------------------------
  // Edge detect, credits, command strobe
  // ----------------------------------------
  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      key_q     <= '0;
      key_prev  <= '0;
      credits   <= CW'(CMD_CREDITS);  // One credit per queue slot
      cmd_valid <= 1'b0;
      key_drop  <= 1'b0;
    end else begin
      key_q     <= keycode;
      key_prev  <= key_q;
      credits   <= credits - CW'(spend) + CW'(cmd_credit);
      cmd_valid <= spend;
      key_drop  <= press && !have_credit;  // Engine queue is full
    end
  end

  always_ff @(posedge Clk) begin
    if (press) begin
      cmd <= key_cmd;
    end
  end

endmodule

// File: verilog/battle_engine.sv
module battle_engine #(
  parameter int CMD_CREDITS = 4
) (
  input  logic               Clk,
  input  logic               arst_n,
  input  logic               cmd_valid,
  input  poke_pkg::cmd_t     cmd,
  output logic               cmd_credit,
  output poke_pkg::hp_t      player_hp,
  output poke_pkg::hp_t      enemy_hp,
  output poke_pkg::mon_idx_t my_cur,
  output poke_pkg::mon_idx_t enemy_cur,
  output logic               battle_over,
  output logic               player_won
);
  import poke_pkg::*;

  localparam int PW = (CMD_CREDITS > 1) ? $clog2(CMD_CREDITS) : 1;
  localparam int CW = $clog2(CMD_CREDITS + 1);

  typedef enum logic [1:0] {
    IDLE,        // Pops the next command
    PLAYER_ACT,
    ENEMY_ACT,
    CHECK
  } state_t;

  cmd_t          q_mem [CMD_CREDITS];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] q_count;
  logic          q_pop;

  state_t   state;
  cmd_t     cur_cmd;  // Command being executed
  move_t    cur_move;

  hp_t      my_hp [TEAM_SIZE];
  hp_t      en_hp [TEAM_SIZE];
  mon_idx_t act_my;   // Working slots, shown after CHECK
  mon_idx_t act_en;

  mon_idx_t sw_c1;
  mon_idx_t sw_c2;
  mon_idx_t sw_slot;
  mon_idx_t low_slot;
  logic     low_found;
  mon_idx_t chk_my;
  mon_idx_t chk_en;
  logic     chk_over;
  logic     chk_won;

  function automatic hp_t sat_sub(hp_t a, hp_t b);
    return (a > b) ? hp_t'(a - b) : '0;
  endfunction

  function automatic mon_idx_t next_slot(mon_idx_t s);
    return (s == mon_idx_t'(TEAM_SIZE - 1)) ? '0 : mon_idx_t'(s + 1'b1);
  endfunction

  function automatic logic [PW-1:0] ptr_inc(logic [PW-1:0] p);
    return (p == PW'(CMD_CREDITS - 1)) ? '0 : PW'(p + 1'b1);
  endfunction

  // ----------------------------------------
  // Command queue
  // ----------------------------------------
  assign q_pop      = (state == IDLE) && (q_count != '0);
  assign cmd_credit = q_pop;  // Slot freed, credit goes back
  assign cur_move   = move_t'(cur_cmd[1:0]);

  always_ff @(posedge Clk) begin
    if (cmd_valid) begin
      q_mem[wr_ptr] <= cmd;
    end
    if (q_pop) begin
      cur_cmd <= q_mem[rd_ptr];
    end
  end

  // Switch target, cyclic from the active slot
  assign sw_c1   = next_slot(act_my);
  assign sw_c2   = next_slot(sw_c1);
  assign sw_slot = (my_hp[sw_c1] != '0) ? sw_c1 :
                   (my_hp[sw_c2] != '0) ? sw_c2 : act_my;

  // Lowest player slot still standing
  always_comb begin
    low_found = 1'b0;
    low_slot  = '0;
    for (int i = TEAM_SIZE - 1; i >= 0; i--) begin
      if (my_hp[i] != '0) begin
        low_found = 1'b1;
        low_slot  = mon_idx_t'(i);
      end
    end
  end

  // Faint replacement and outcome
  always_comb begin
    chk_my   = act_my;
    chk_en   = act_en;
    chk_over = battle_over;
    chk_won  = player_won;
    if (cur_cmd == CMD_RESTART) begin
      chk_over = 1'b0;
      chk_won  = 1'b0;
    end else if (!battle_over) begin
      if (en_hp[act_en] == '0) begin
        if (act_en == mon_idx_t'(TEAM_SIZE - 1)) begin
          chk_over = 1'b1;  // Last enemy down
          chk_won  = 1'b1;
        end else begin
          chk_en = next_slot(act_en);
        end
      end else if (my_hp[act_my] == '0) begin
        if (low_found) begin
          chk_my = low_slot;
        end else begin
          chk_over = 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // Battle FSM
  // ----------------------------------------
  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= IDLE;
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      q_count     <= '0;
      for (int i = 0; i < TEAM_SIZE; i++) begin
        my_hp[i] <= MY_MAX_HP[i];
        en_hp[i] <= ENEMY_MAX_HP[i];
      end
      act_my      <= '0;
      act_en      <= '0;
      player_hp   <= MY_MAX_HP[0];
      enemy_hp    <= ENEMY_MAX_HP[0];
      my_cur      <= '0;
      enemy_cur   <= '0;
      battle_over <= 1'b0;
      player_won  <= 1'b0;
    end else begin
      if (cmd_valid) wr_ptr <= ptr_inc(wr_ptr);
      if (q_pop)     rd_ptr <= ptr_inc(rd_ptr);
      q_count <= q_count + CW'(cmd_valid) - CW'(q_pop);

      case (state)
        IDLE: begin
          if (q_pop) state <= PLAYER_ACT;
        end
        PLAYER_ACT: begin
          if (cur_cmd == CMD_RESTART) begin
            for (int i = 0; i < TEAM_SIZE; i++) begin
              my_hp[i] <= MY_MAX_HP[i];
              en_hp[i] <= ENEMY_MAX_HP[i];
            end
            act_my <= '0;
            act_en <= '0;
          end else if (!battle_over) begin
            if (cur_cmd == CMD_SWITCH) begin
              act_my <= sw_slot;
            end else begin
              en_hp[act_en] <= sat_sub(en_hp[act_en], MOVE_POWER[cur_move]);
            end
          end
          state <= ENEMY_ACT;
        end
        ENEMY_ACT: begin
          // Counterattack only from a living enemy
          if (!battle_over && cur_cmd != CMD_RESTART && en_hp[act_en] != '0) begin
            my_hp[act_my] <= sat_sub(my_hp[act_my], ENEMY_POWER[act_en]);
          end
          state <= CHECK;
        end
        CHECK: begin
          act_my      <= chk_my;
          act_en      <= chk_en;
          player_hp   <= my_hp[chk_my];
          enemy_hp    <= en_hp[chk_en];
          my_cur      <= chk_my;
          enemy_cur   <= chk_en;
          battle_over <= chk_over;
          player_won  <= chk_won;
          state       <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: verilog/battle_report.sv
module battle_report (
  input  logic                Clk,
  input  logic                arst_n,
  input  poke_pkg::hp_t       player_hp,
  input  poke_pkg::mon_idx_t  my_cur,
  input  logic                battle_over,
  input  logic                player_won,
  output logic [6:0]          hex0,
  output logic [6:0]          hex1,
  output poke_pkg::hp_class_t hp_class,
  output logic                end_battle,
  output logic                result
);
  import poke_pkg::*;

  logic [9:0] hp_x2;
  logic [9:0] hp_x4;
  logic [9:0] max_w;  // Max HP of the active monster
  hp_class_t  class_next;

  // Segments gfedcba, active low
  function automatic logic [6:0] seg7(logic [3:0] nib);
    case (nib)
      4'h0:    return 7'b1000000;
      4'h1:    return 7'b1111001;
      4'h2:    return 7'b0100100;
      4'h3:    return 7'b0110000;
      4'h4:    return 7'b0011001;
      4'h5:    return 7'b0010010;
      4'h6:    return 7'b0000010;
      4'h7:    return 7'b1111000;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0010000;
      4'hA:    return 7'b0001000;
      4'hB:    return 7'b0000011;
      4'hC:    return 7'b1000110;
      4'hD:    return 7'b0100001;
      4'hE:    return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  // ----------------------------------------
  // HP bar class
  // ----------------------------------------
  assign hp_x2 = {1'b0, player_hp, 1'b0};
  assign hp_x4 = {player_hp, 2'b00};
  assign max_w = {2'b00, MY_MAX_HP[my_cur]};

  assign class_next = (hp_x2 > max_w) ? HP_GREEN :   // Above half
                      (hp_x4 > max_w) ? HP_YELLOW :  // Above a quarter
                                        HP_RED;

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      hex0       <= seg7(MY_MAX_HP[0][3:0]);
      hex1       <= seg7(MY_MAX_HP[0][7:4]);
      hp_class   <= HP_GREEN;
      end_battle <= 1'b0;
      result     <= 1'b0;
    end else begin
      hex0       <= seg7(player_hp[3:0]);
      hex1       <= seg7(player_hp[7:4]);
      hp_class   <= class_next;
      end_battle <= battle_over;
      result     <= player_won;  // 1 means the player won
    end
  end

endmodule

// File: verilog/poke_battle_top.sv
module poke_battle_top #(
  parameter int CMD_CREDITS = 4
) (
  input  logic                Clk,
  input  logic                arst_n,
  input  poke_pkg::keycode_t  keycode,
  output logic [6:0]          hex0,
  output logic [6:0]          hex1,
  output poke_pkg::hp_t       player_hp,
  output poke_pkg::hp_t       enemy_hp,
  output poke_pkg::mon_idx_t  my_cur,
  output poke_pkg::mon_idx_t  enemy_cur,
  output poke_pkg::hp_class_t hp_class,
  output logic                end_battle,
  output logic                result,
  output logic                key_drop
);
  import poke_pkg::*;

  logic cmd_valid;
  cmd_t cmd;
  logic cmd_credit;   // Returned by the engine on each pop
  logic battle_over;
  logic player_won;

  key_decode #(
    .CMD_CREDITS(CMD_CREDITS)
  ) i_key_decode (
    .Clk        (Clk),
    .arst_n     (arst_n),
    .keycode    (keycode),
    .cmd_credit (cmd_credit),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .key_drop   (key_drop)
  );

  battle_engine #(
    .CMD_CREDITS(CMD_CREDITS)
  ) i_battle_engine (
    .Clk         (Clk),
    .arst_n      (arst_n),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cmd_credit  (cmd_credit),
    .player_hp   (player_hp),
    .enemy_hp    (enemy_hp),
    .my_cur      (my_cur),
    .enemy_cur   (enemy_cur),
    .battle_over (battle_over),
    .player_won  (player_won)
  );

  // Display side
  battle_report i_battle_report (
    .Clk         (Clk),
    .arst_n      (arst_n),
    .player_hp   (player_hp),
    .my_cur      (my_cur),
    .battle_over (battle_over),
    .player_won  (player_won),
    .hex0        (hex0),
    .hex1        (hex1),
    .hp_class    (hp_class),
    .end_battle  (end_battle),
    .result      (result)
  );

endmodule

// File: sim/poke_battle_asserts.sv
module poke_battle_asserts #(
  parameter int CMD_CREDITS = 4
) (
  input logic                                Clk,
  input logic                                arst_n,
  input logic                                cmd_valid,
  input logic                                cmd_credit,
  input logic [$clog2(CMD_CREDITS + 1)-1:0]  q_count,
  input poke_pkg::hp_t                       player_hp,
  input poke_pkg::hp_t                       enemy_hp,
  input poke_pkg::mon_idx_t                  my_cur,
  input poke_pkg::mon_idx_t                  enemy_cur
);
  timeunit 1ns;
  timeprecision 1ps;
  import poke_pkg::*;

  int pending;  // Commands taken in and not yet popped

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= 0;
    end else begin
      pending <= pending + int'(cmd_valid) - int'(cmd_credit);
    end
  end

  // ----------------------------------------
  // Credit protocol
  // ----------------------------------------
  a_credit_needs_cmd: assert property (@(posedge Clk) disable iff (!arst_n)
    cmd_credit |-> (pending > 0))
    else $error("cmd_credit pulsed with an empty command queue");

  a_queue_bound: assert property (@(posedge Clk) disable iff (!arst_n)
    int'(q_count) <= CMD_CREDITS)  // Credits bound the queue
    else $error("command queue holds more than CMD_CREDITS entries");

  // ----------------------------------------
  // HP bounds
  // ----------------------------------------
  a_player_hp_max: assert property (@(posedge Clk) disable iff (!arst_n)
    (int'(my_cur) < TEAM_SIZE) && (player_hp <= MY_MAX_HP[my_cur]))
    else $error("player HP above the table maximum of its slot");

  a_enemy_hp_max: assert property (@(posedge Clk) disable iff (!arst_n)
    (int'(enemy_cur) < TEAM_SIZE) && (enemy_hp <= ENEMY_MAX_HP[enemy_cur]))
    else $error("enemy HP above the table maximum of its slot");

endmodule

bind battle_engine poke_battle_asserts #(
  .CMD_CREDITS(CMD_CREDITS)
) i_poke_battle_asserts (
  .Clk        (Clk),
  .arst_n     (arst_n),
  .cmd_valid  (cmd_valid),
  .cmd_credit (cmd_credit),
  .q_count    (q_count),
  .player_hp  (player_hp),
  .enemy_hp   (enemy_hp),
  .my_cur     (my_cur),
  .enemy_cur  (enemy_cur)
);

// File: sim/poke_battle_tb.sv
module poke_battle_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import poke_pkg::*;

  localparam int CMD_CREDITS   = 4;
  localparam int CLK_PERIOD    = 100;
  localparam int N_SPACED      = 8;
  localparam int BURST_LEN     = 10;
  localparam int MAX_END_MOVES = 40;
  localparam int N_PRESSES     = N_SPACED + BURST_LEN + MAX_END_MOVES + 10;
  localparam int SETTLE_LIMIT  = 8 * CMD_CREDITS + 20;

  logic       Clk;
  logic       arst_n;
  keycode_t   keycode;
  logic [6:0] hex0;
  logic [6:0] hex1;
  hp_t        player_hp;
  hp_t        enemy_hp;
  mon_idx_t   my_cur;
  mon_idx_t   enemy_cur;
  hp_class_t  hp_class;
  logic       end_battle;
  logic       result;
  logic       key_drop;

  int seed;
  int checks;
  int errors;
  int test_errors;
  int tests_passed;
  int tests_failed;

  // Reference battle model
  int m_my_hp [TEAM_SIZE];
  int m_en_hp [TEAM_SIZE];
  int m_my;
  int m_en;
  bit m_over;
  bit m_won;

  poke_battle_top #(
    .CMD_CREDITS(CMD_CREDITS)
  ) i_poke_battle_top (
    .Clk        (Clk),
    .arst_n     (arst_n),
    .keycode    (keycode),
    .hex0       (hex0),
    .hex1       (hex1),
    .player_hp  (player_hp),
    .enemy_hp   (enemy_hp),
    .my_cur     (my_cur),
    .enemy_cur  (enemy_cur),
    .hp_class   (hp_class),
    .end_battle (end_battle),
    .result     (result),
    .key_drop   (key_drop)
  );

  initial begin
    Clk = 1'b0;
    forever #(CLK_PERIOD / 2) Clk = ~Clk;
  end

  // Watchdog, 40 cycles per press plus margin
  initial begin
    #((N_PRESSES * 40 + 200) * CLK_PERIOD);
    $display("Failure: time limit reached before the tests finished");
    $display("=== FAIL ===");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic int rand_below(int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic int clamp_zero(int v);
    return (v < 0) ? 0 : v;
  endfunction

  function automatic keycode_t key_of(int idx);
    case (idx)
      0:       return KEY_A;
      1:       return KEY_S;
      2:       return KEY_D;
      3:       return KEY_F;
      4:       return KEY_SPACE;
      default: return KEY_ENTER;
    endcase
  endfunction

  function automatic bit is_mapped(keycode_t key);
    return key == KEY_A || key == KEY_S || key == KEY_D || key == KEY_F ||
           key == KEY_SPACE || key == KEY_ENTER;
  endfunction

  function automatic int move_index(keycode_t key);
    case (key)
      KEY_S:   return 1;
      KEY_D:   return 2;
      KEY_F:   return 3;
      default: return 0;
    endcase
  endfunction

  // Active-high gfedcba table, display is active low
  function automatic logic [6:0] seg_pattern(int nib);
    logic [6:0] seg;
    case (nib)
      0:       seg = 7'h3F;
      1:       seg = 7'h06;
      2:       seg = 7'h5B;
      3:       seg = 7'h4F;
      4:       seg = 7'h66;
      5:       seg = 7'h6D;
      6:       seg = 7'h7D;
      7:       seg = 7'h07;
      8:       seg = 7'h7F;
      9:       seg = 7'h6F;
      10:      seg = 7'h77;
      11:      seg = 7'h7C;
      12:      seg = 7'h39;
      13:      seg = 7'h5E;
      14:      seg = 7'h79;
      default: seg = 7'h71;
    endcase
    return ~seg;
  endfunction

  task automatic check_value(string name, int expected, int actual);
    checks++;
    if (expected != actual) begin
      $display("Error at %0d ns: %s expected %0d, actual %0d", $time, name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic fail_note(string what);
    $display("Failure at %0d ns: %s", $time, what);
    errors++;
    test_errors++;
  endtask

  task automatic finish_test(int num, string name);
    if (test_errors == 0) begin
      $display("Test %0d %s: passed", num, name);
      tests_passed++;
    end else begin
      $display("Test %0d %s: failed with %0d errors", num, name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  task automatic model_reset();
    for (int i = 0; i < TEAM_SIZE; i++) begin
      m_my_hp[i] = int'(MY_MAX_HP[i]);
      m_en_hp[i] = int'(ENEMY_MAX_HP[i]);
    end
    m_my   = 0;
    m_en   = 0;
    m_over = 1'b0;
    m_won  = 1'b0;
  endtask

  task automatic model_press(keycode_t key);
    int  tgt;
    int  s;
    bit  found;
    tgt   = m_my;
    found = 1'b0;
    if (key == KEY_ENTER) begin
      model_reset();
    end else if (!m_over) begin
      if (key == KEY_SPACE) begin
        for (int k = 1; k < TEAM_SIZE; k++) begin
          s = (m_my + k) % TEAM_SIZE;
          if (!found && m_my_hp[s] > 0) begin
            found = 1'b1;
            tgt   = s;
          end
        end
        m_my = tgt;
      end else begin
        m_en_hp[m_en] = clamp_zero(m_en_hp[m_en] - int'(MOVE_POWER[move_index(key)]));
      end
      if (m_en_hp[m_en] > 0) begin  // Counterattack
        m_my_hp[m_my] = clamp_zero(m_my_hp[m_my] - int'(ENEMY_POWER[m_en]));
      end
      found = 1'b0;
      if (m_en_hp[m_en] == 0) begin
        if (m_en == TEAM_SIZE - 1) begin
          m_over = 1'b1;
          m_won  = 1'b1;
        end else begin
          m_en++;
        end
      end else if (m_my_hp[m_my] == 0) begin
        for (int k = TEAM_SIZE - 1; k >= 0; k--) begin
          if (m_my_hp[k] > 0) begin
            found = 1'b1;
            tgt   = k;
          end
        end
        if (found) begin
          m_my = tgt;
        end else begin
          m_over = 1'b1;  // Whole team fainted
        end
      end
    end
  endtask

  task automatic check_outputs();
    int        hp;
    int        max_hp;
    hp_class_t exp_class;
    hp        = m_my_hp[m_my];
    max_hp    = int'(MY_MAX_HP[m_my]);
    exp_class = (2 * hp > max_hp) ? HP_GREEN : (4 * hp > max_hp) ? HP_YELLOW : HP_RED;
    check_value("player_hp", hp, int'(player_hp));
    check_value("enemy_hp", m_en_hp[m_en], int'(enemy_hp));
    check_value("my_cur", m_my, int'(my_cur));
    check_value("enemy_cur", m_en, int'(enemy_cur));
    check_value("hp_class", int'(exp_class), int'(hp_class));
    check_value("hex0", int'(seg_pattern(hp % 16)), int'(hex0));
    check_value("hex1", int'(seg_pattern(hp / 16)), int'(hex1));
    check_value("end_battle", int'(m_over), int'(end_battle));
    check_value("result", int'(m_won), int'(result));
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic step();
    @(posedge Clk);
    #5;
  endtask

  // Waits for the engine queue to drain, then for the last command and the report
  task automatic settle();
    int guard;
    guard = 0;
    step();
    while (i_poke_battle_top.i_battle_engine.q_count != '0) begin
      step();
      guard++;
      if (guard > SETTLE_LIMIT) begin
        fail_note("the engine command queue did not drain");
        break;
      end
    end
    repeat (4) step();
  endtask

  // Drop flag is registered two edges after the drive edge
  task automatic press_key(keycode_t key);
    bit dropped;
    step();
    keycode = key;
    step();
    keycode = '0;
    step();
    dropped = key_drop;
    if (dropped) begin
      fail_note("a spaced key press was dropped");
    end else if (is_mapped(key)) begin
      model_press(key);
    end
    repeat (rand_below(3)) step();
    settle();
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_burst();
    keycode_t bkeys [BURST_LEN];
    bit       bdrop [BURST_LEN];
    keycode_t prev;
    int       drops;
    prev  = '0;
    drops = 0;
    for (int i = 0; i < BURST_LEN; i++) begin
      do begin
        bkeys[i] = key_of(rand_below(5));
      end while (bkeys[i] == prev);  // Each edge must be a new press
      prev = bkeys[i];
    end
    for (int i = 0; i < BURST_LEN + 2; i++) begin
      step();
      if (i >= 2) begin
        bdrop[i-2] = key_drop;
      end
      keycode = (i < BURST_LEN) ? bkeys[i] : '0;
    end
    for (int i = 0; i < BURST_LEN; i++) begin
      if (bdrop[i]) begin
        drops++;
      end else begin
        model_press(bkeys[i]);
      end
    end
    settle();
    check_outputs();
    // A command holds the engine 4 cycles, so few credits return inside the burst
    if (drops < BURST_LEN - CMD_CREDITS - BURST_LEN / 4) begin
      fail_note("too few key presses were dropped during the burst");
    end
    if (drops > BURST_LEN - CMD_CREDITS) begin
      fail_note("more key presses were dropped than the credits allow");
    end
  endtask

  task automatic test_play_to_end();
    int n;
    int hp_before;
    int en_before;
    n = 0;
    press_key(KEY_ENTER);  // Fresh battle
    while (!m_over && n < MAX_END_MOVES) begin
      press_key(key_of(rand_below(4)));
      check_outputs();
      n++;
    end
    if (!m_over) begin
      fail_note("the model battle did not end within the move limit");
    end
    check_value("end_battle", 1, int'(end_battle));
    hp_before = int'(player_hp);
    en_before = int'(enemy_hp);
    repeat (3) press_key(key_of(rand_below(4)));
    check_value("player_hp", hp_before, int'(player_hp));
    check_value("enemy_hp", en_before, int'(enemy_hp));
    check_outputs();
  endtask

  task automatic test_restart();
    int r;
    press_key(KEY_ENTER);
    check_outputs();
    check_value("player_hp", int'(MY_MAX_HP[0]), int'(player_hp));
    check_value("enemy_hp", int'(ENEMY_MAX_HP[0]), int'(enemy_hp));
    check_value("end_battle", 0, int'(end_battle));
    for (int i = 0; i < 3; i++) begin
      do begin
        r = rand_below(256);
      end while (r == 0 || is_mapped(keycode_t'(r)));
      press_key(keycode_t'(r));
      check_outputs();
    end
  endtask

  initial begin
    seed         = 32'hf8eeed4c;
    checks       = 0;
    errors       = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    keycode      = '0;
    arst_n       = 1'b0;
    model_reset();
    repeat (5) @(posedge Clk);
    #5;
    arst_n = 1'b1;

    step();
    check_outputs();
    finish_test(1, "reset state");

    for (int i = 0; i < N_SPACED; i++) begin
      press_key(key_of(rand_below(5)));
      check_outputs();
    end
    finish_test(2, "spaced moves and switches");

    test_burst();
    finish_test(3, "press burst");
    test_play_to_end();
    finish_test(4, "battle to the end");
    test_restart();
    finish_test(5, "restart and unmapped keys");

    $display("Tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: src.f
verilog/poke_pkg.sv
verilog/key_decode.sv
verilog/battle_engine.sv
verilog/battle_report.sv
verilog/poke_battle_top.sv
sim/poke_battle_asserts.sv
sim/poke_battle_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the battle core testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module poke_battle_tb \
  --Mdir obj_dir \
  -f src.f

# A failed assertion may stop the run early; the log search decides the result
./obj_dir/Vpoke_battle_tb > sim.log 2>&1 || true
cat sim.log

if grep -q '^=== PASS ===$' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
